/* flist.f */
rtl/muldiv_pkg.sv
rtl/muldiv_issue.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/muldiv_top.sv
verification/tb_muldiv.sv

/* rtl/div_unit.sv */
// --------------------------------------------------------------------------
// Restoring shift-subtract divider for DIV, DIVU, REM and REMU.
// Works on magnitudes, one quotient bit per cycle, and corrects the sign
// on return. A zero divisor returns all ones and the dividend unchanged.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module div_unit
    import muldiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         start_i,
    input  wire         signed_i,
    input  wire         rem_i,
    input  xlen_t       src1_i,
    input  xlen_t       src2_i,
    output logic        done_o,
    output xlen_t       rslt_o
);

    div_state_e    state_q;
    step_cnt_t     cnt_q;
    xlen_t         divisor_q;
    dword_t        pair_q;                       // {remainder, quotient}
    logic          dvd_neg_q;
    logic          dvs_neg_q;
    logic          quo_neg_q;                    // quotient sign
    logic          rem_neg_q;                    // remainder follows dividend
    logic          rem_sel_q;

    xlen_t         remainder;
    xlen_t         quotient;
    xlen_t         dvd_mag;
    xlen_t         dvs_mag;
    logic          divisor_zero;
    logic [XLEN:0] diff;
    logic          q_bit;

    assign remainder    = pair_q[2*XLEN-1:XLEN];
    assign quotient     = pair_q[XLEN-1:0];
    assign dvd_mag      = dvd_neg_q ? -remainder : remainder;  // dividend sits in upper half
    assign dvs_mag      = dvs_neg_q ? -divisor_q : divisor_q;
    assign divisor_zero = (divisor_q == '0);

    // trial subtraction of the shifted partial remainder
    assign diff  = {1'b0, pair_q[2*XLEN-2:XLEN-1]} - {1'b0, divisor_q};
    assign q_bit = ~diff[XLEN];

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_CHECK;
                    end
                end
                DIV_CHECK: state_q <= divisor_zero ? DIV_RET : DIV_EXEC;
                DIV_EXEC: begin
                    if (cnt_q == '0) begin
                        state_q <= DIV_RET;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_sel_q <= rem_i;
                    dvd_neg_q <= signed_i & src1_i[XLEN-1];
                    dvs_neg_q <= signed_i & src2_i[XLEN-1];
                    quo_neg_q <= signed_i & (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
                    rem_neg_q <= signed_i & src1_i[XLEN-1];
                    divisor_q <= src2_i;
                    pair_q    <= {src1_i, {XLEN{1'b0}}};
                end
            end
            DIV_CHECK: begin
                if (divisor_zero) begin
                    pair_q    <= {remainder, {XLEN{1'b1}}};  // quotient all ones
                    quo_neg_q <= 1'b0;
                    rem_neg_q <= 1'b0;
                end else begin
                    divisor_q <= dvs_mag;
                    pair_q    <= {{XLEN{1'b0}}, dvd_mag};
                    cnt_q     <= step_cnt_t'(DIV_STEPS - 1);
                end
            end
            DIV_EXEC: begin
                if (q_bit) begin
                    pair_q <= {diff[XLEN-1:0], pair_q[XLEN-2:0], 1'b1};
                end else begin
                    pair_q <= {pair_q[2*XLEN-2:0], 1'b0};
                end
                cnt_q <= cnt_q - 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign done_o = (state_q == DIV_RET);
    assign rslt_o = rem_sel_q ? (rem_neg_q ? -remainder : remainder)
                              : (quo_neg_q ? -quotient : quotient);

endmodule

`default_nettype wire

/* rtl/mul_unit.sv */
// --------------------------------------------------------------------------
// Two-step multiplier for MUL, MULH, MULHSU and MULHU. Operands are
// extended to 33 bits on start, the signed product is registered in the
// next cycle and done_o marks the low or high half in the cycle after.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import muldiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         start_i,
    input  wire         src1_signed_i,
    input  wire         src2_signed_i,
    input  wire         high_i,
    input  xlen_t       src1_i,
    input  xlen_t       src2_i,
    output logic        done_o,
    output xlen_t       rslt_o
);

    mul_state_e           state_q;
    logic signed [XLEN:0] src1_ext_q;            // sign or zero extended
    logic signed [XLEN:0] src2_ext_q;
    logic                 high_q;
    dword_t               product_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MUL_IDLE;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_EXEC;
                    end
                end
                MUL_EXEC: state_q <= MUL_RET;
                default:  state_q <= MUL_IDLE;
            endcase
        end
    end

    // operand capture and product
    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE && start_i) begin
            src1_ext_q <= {src1_signed_i & src1_i[XLEN-1], src1_i};
            src2_ext_q <= {src2_signed_i & src2_i[XLEN-1], src2_i};
            high_q     <= high_i;
        end
        if (state_q == MUL_EXEC) begin
            product_q <= src1_ext_q * src2_ext_q;  // 33x33 signed, low 64 bits kept
        end
    end

    assign done_o = (state_q == MUL_RET);
    assign rslt_o = high_q ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];

endmodule

`default_nettype wire

/* rtl/muldiv_issue.sv */
// --------------------------------------------------------------------------
// Issue stage of the multiply/divide unit. Accepts one request at a time,
// decodes funct3 into a start strobe and controls for the multiplier or
// the divider, holds busy until the result strobe and returns the result.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_issue
    import muldiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         req_valid_i,
    input  muldiv_op_e  req_op_i,
    input  wire         mul_done_i,
    input  xlen_t       mul_rslt_i,
    input  wire         div_done_i,
    input  xlen_t       div_rslt_i,
    output logic        busy_o,
    output logic        mul_start_o,
    output logic        src1_signed_o,
    output logic        src2_signed_o,
    output logic        mul_high_o,
    output logic        div_start_o,
    output logic        div_signed_o,
    output logic        div_rem_o,
    output logic        rslt_valid_o,
    output xlen_t       rslt_o
);

    logic busy_q;
    logic accept;
    logic div_op;

    assign accept = req_valid_i & ~busy_q;       // requests while busy are dropped

    // ----------------------------------------------------------------------
    // funct3 decode
    // ----------------------------------------------------------------------
    always_comb begin
        div_op        = 1'b0;
        src1_signed_o = 1'b0;
        src2_signed_o = 1'b0;
        mul_high_o    = 1'b1;                    // all but MUL take the high half
        div_signed_o  = 1'b0;
        div_rem_o     = 1'b0;
        case (req_op_i)
            OP_MUL: begin
                mul_high_o = 1'b0;
            end
            OP_MULH: begin
                src1_signed_o = 1'b1;
                src2_signed_o = 1'b1;
            end
            OP_MULHSU: begin
                src1_signed_o = 1'b1;
            end
            OP_MULHU: begin
                mul_high_o = 1'b1;
            end
            OP_DIV: begin
                div_op       = 1'b1;
                div_signed_o = 1'b1;
            end
            OP_DIVU: begin
                div_op = 1'b1;
            end
            OP_REM: begin
                div_op       = 1'b1;
                div_signed_o = 1'b1;
                div_rem_o    = 1'b1;
            end
            default: begin                       // REMU
                div_op    = 1'b1;
                div_rem_o = 1'b1;
            end
        endcase
    end

    assign mul_start_o = accept & ~div_op;
    assign div_start_o = accept & div_op;

    // busy from the accepting edge to the edge after the result strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (rslt_valid_o) begin
            busy_q <= 1'b0;
        end
    end

    assign busy_o = busy_q;

    // return path, only one unit finishes at a time
    assign rslt_valid_o = mul_done_i | div_done_i;
    assign rslt_o       = div_done_i ? div_rslt_i : mul_rslt_i;

endmodule

`default_nettype wire

/* rtl/muldiv_pkg.sv */
// --------------------------------------------------------------------------
// Shared definitions for the RV32 M-extension multiply/divide unit.
// Holds the data widths, the funct3 operation codes and the FSM state
// encodings. The RTL and the testbench import it.
// --------------------------------------------------------------------------
`default_nettype none

package muldiv_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int XLEN       = 32;              // RV32 data word
    localparam int DIV_STEPS  = XLEN;            // one quotient bit per cycle
    localparam int STEP_CNT_W = $clog2(DIV_STEPS);

    typedef logic [XLEN-1:0]       xlen_t;       // operands and results
    typedef logic [2*XLEN-1:0]     dword_t;      // product or rem/quo pair
    typedef logic [STEP_CNT_W-1:0] step_cnt_t;   // divide step counter

    // ----------------------------------------------------------------------
    // operation codes, same as funct3 of the OP/M instructions
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

    // multiplier FSM
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_EXEC,                                // product register loads
        MUL_RET
    } mul_state_e;

    // divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,                               // magnitudes, zero divisor
        DIV_EXEC,                                // shift-subtract steps
        DIV_RET
    } div_state_e;

endpackage

`default_nettype wire

/* rtl/muldiv_top.sv */
// --------------------------------------------------------------------------
// Top level of the multiply/divide unit. The issue stage drives both
// execution units; request operands go straight to both of them.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_top
    import muldiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         req_valid_i,
    input  muldiv_op_e  req_op_i,
    input  xlen_t       req_src1_i,
    input  xlen_t       req_src2_i,
    output logic        busy_o,
    output logic        rslt_valid_o,
    output xlen_t       rslt_o
);

    logic  mul_start;
    logic  src1_signed;
    logic  src2_signed;
    logic  mul_high;
    logic  mul_done;
    xlen_t mul_rslt;
    logic  div_start;
    logic  div_signed;
    logic  div_rem;
    logic  div_done;
    xlen_t div_rslt;

    muldiv_issue i_muldiv_issue (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .mul_done_i     (mul_done),
        .mul_rslt_i     (mul_rslt),
        .div_done_i     (div_done),
        .div_rslt_i     (div_rslt),
        .busy_o         (busy_o),
        .mul_start_o    (mul_start),
        .src1_signed_o  (src1_signed),
        .src2_signed_o  (src2_signed),
        .mul_high_o     (mul_high),
        .div_start_o    (div_start),
        .div_signed_o   (div_signed),
        .div_rem_o      (div_rem),
        .rslt_valid_o   (rslt_valid_o),
        .rslt_o         (rslt_o)
    );

    mul_unit i_mul_unit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (mul_start),
        .src1_signed_i  (src1_signed),
        .src2_signed_i  (src2_signed),
        .high_i         (mul_high),
        .src1_i         (req_src1_i),
        .src2_i         (req_src2_i),
        .done_o         (mul_done),
        .rslt_o         (mul_rslt)
    );

    div_unit i_div_unit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (div_start),
        .signed_i       (div_signed),
        .rem_i          (div_rem),
        .src1_i         (req_src1_i),
        .src2_i         (req_src2_i),
        .done_o         (div_done),
        .rslt_o         (div_rslt)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply/divide testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal \
    -f flist.f \
    --top-module tb_muldiv \
    -o sim_muldiv

./obj_dir/sim_muldiv > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"

/* verification/tb_muldiv.sv */
// --------------------------------------------------------------------------
// Directed testbench for the multiply/divide unit. Drives all eight M
// operations on corner and LFSR operands, checks each result against a
// 64-bit reference model, and covers divide by zero, signed overflow and
// the dropping of requests while busy. Built and run by run_sim.sh.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int          RST_CYCLES  = 16;
    localparam logic [31:0] LFSR_SEED   = 32'h9f82c68a;
    // corners, random mul, random div, mixed sign, zero divisor, overflow, busy drop
    localparam int          NUM_REQS    = 4*25 + 4*40 + 4*20 + 4*4 + 4*3 + 2 + 3;
    localparam int          CYCLE_LIMIT = NUM_REQS * (DIV_STEPS + 8) + RST_CYCLES;

    logic       clk_i;
    logic       rst_i;
    logic       req_valid_i;
    muldiv_op_e req_op_i;
    xlen_t      req_src1_i;
    xlen_t      req_src2_i;
    logic       busy_o;
    logic       rslt_valid_o;
    xlen_t      rslt_o;

    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          rslt_cnt;                          // result strobes seen so far

    muldiv_top i_muldiv_top (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_src1_i   (req_src1_i),
        .req_src2_i   (req_src2_i),
        .busy_o       (busy_o),
        .rslt_valid_o (rslt_valid_o),
        .rslt_o       (rslt_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (rst_i) begin
            rslt_cnt <= 0;
        end else if (rslt_valid_o) begin
            rslt_cnt <= rslt_cnt + 1;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "simulation timeout");
        end
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output xlen_t w);
        int i;
        w = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[XLEN-2:0], lfsr_q[0]};      // one step per bit
        end
    endtask

    // RISC-V M semantics on 64-bit arithmetic
    function automatic xlen_t ref_result(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        logic signed [2*XLEN-1:0] ua;
        logic signed [2*XLEN-1:0] ub;
        logic signed [2*XLEN-1:0] res;
        logic                     ovf;
        sa  = {{XLEN{a[XLEN-1]}}, a};
        sb  = {{XLEN{b[XLEN-1]}}, b};
        ua  = {{XLEN{1'b0}}, a};
        ub  = {{XLEN{1'b0}}, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            OP_MUL:    res = sa * sb;
            OP_MULH:   res = (sa * sb) >>> XLEN;
            OP_MULHSU: res = (sa * ub) >>> XLEN;
            OP_MULHU:  res = (ua * ub) >> XLEN;
            OP_DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (ovf) begin
                    res = sa;
                end else begin
                    res = sa / sb;
                end
            end
            OP_DIVU:   res = (b == '0) ? '1 : ua / ub;
            OP_REM: begin
                if (b == '0) begin
                    res = sa;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    res = sa % sb;
                end
            end
            default:   res = (b == '0) ? ua : ua % ub;
        endcase
        return res[XLEN-1:0];
    endfunction

    task automatic check_equal(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // one-cycle strobe sampled by the DUT on the second edge
    task automatic start_req(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_src1_i  <= a;
        req_src2_i  <= b;
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic wait_result(output xlen_t r, output int lat);
        lat = 0;
        do begin
            @(negedge clk_i);
            lat++;
        end while (!rslt_valid_o);
        r = rslt_o;
    endtask

    task automatic run_op(input muldiv_op_e op, input xlen_t a, input xlen_t b,
                          input xlen_t exp);
        xlen_t r;
        int    lat;
        start_req(op, a, b);
        wait_result(r, lat);
        check_equal(r, exp, $sformatf("%s %h, %h", op.name(), a, b));
        if (op < OP_DIV) begin
            check_equal(xlen_t'(lat), 32'd2, "multiply latency");
        end
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic idle_after_reset();
        repeat (4) begin
            @(negedge clk_i);
            check_equal({31'b0, busy_o}, 32'd0, "busy_o idle after reset");
            check_equal({31'b0, rslt_valid_o}, 32'd0, "rslt_valid_o idle after reset");
        end
    endtask

    task automatic mul_corner_ops();
        xlen_t      corners [5];
        muldiv_op_e op;
        int         k;
        int         i;
        int         j;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (k = 0; k < 4; k++) begin
            op = muldiv_op_e'(k);
            for (i = 0; i < 5; i++) begin
                for (j = 0; j < 5; j++) begin
                    run_op(op, corners[i], corners[j], ref_result(op, corners[i], corners[j]));
                end
            end
        end
    endtask

    task automatic random_ops(input int first_op, input int pairs);
        xlen_t      a;
        xlen_t      b;
        xlen_t      sh;
        muldiv_op_e op;
        int         i;
        int         k;
        for (i = 0; i < pairs; i++) begin
            rand_bits(XLEN, a);
            rand_bits(XLEN, b);
            if (first_op >= 4) begin
                rand_bits(5, sh);
                b = b >> sh;                        // spread divisor sizes
            end
            for (k = first_op; k < first_op + 4; k++) begin
                op = muldiv_op_e'(k);
                run_op(op, a, b, ref_result(op, a, b));
            end
        end
    endtask

    task automatic div_mixed_sign();
        xlen_t      a;
        xlen_t      b;
        muldiv_op_e op;
        int         i;
        int         k;
        for (i = 0; i < 4; i++) begin
            a = i[0] ? -32'd1000003 : 32'd1000003;
            b = i[1] ? -32'd97 : 32'd97;
            for (k = 4; k < 8; k++) begin
                op = muldiv_op_e'(k);
                run_op(op, a, b, ref_result(op, a, b));
            end
        end
    endtask

    task automatic div_special_cases();
        xlen_t dvd [3];
        int    i;
        dvd = '{32'h1234_5678, 32'h8000_0000, 32'hffff_fff5};
        for (i = 0; i < 3; i++) begin
            run_op(OP_DIV,  dvd[i], 32'h0, 32'hffff_ffff);
            run_op(OP_DIVU, dvd[i], 32'h0, 32'hffff_ffff);
            run_op(OP_REM,  dvd[i], 32'h0, dvd[i]);
            run_op(OP_REMU, dvd[i], 32'h0, dvd[i]);
        end
        run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        run_op(OP_REM, 32'h8000_0000, 32'hffff_ffff, 32'h0);
    endtask

    task automatic drop_while_busy();
        xlen_t r;
        int    lat;
        int    cnt_before;
        @(negedge clk_i);
        cnt_before = rslt_cnt;
        start_req(OP_DIV, 32'h7fff_1234, 32'h0000_0123);
        repeat (3) @(negedge clk_i);
        check_equal({31'b0, busy_o}, 32'd1, "busy_o during divide");
        start_req(OP_MUL, 32'd3, 32'd5);            // must be dropped
        wait_result(r, lat);
        check_equal(r, ref_result(OP_DIV, 32'h7fff_1234, 32'h0000_0123),
                    "result with a dropped request");
        run_op(OP_REM, 32'hffff_8001, 32'h0000_0033, ref_result(OP_REM, 32'hffff_8001, 32'h33));
        @(negedge clk_i);
        check_equal(xlen_t'(rslt_cnt - cnt_before), 32'd2, "result strobes around a drop");
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = OP_MUL;
        req_src1_i  = '0;
        req_src2_i  = '0;
        lfsr_q      = LFSR_SEED;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        idle_after_reset();
        mul_corner_ops();
        random_ops(0, 40);                          // MUL .. MULHU
        random_ops(4, 20);                          // DIV .. REMU
        div_mixed_sign();
        div_special_cases();
        drop_while_busy();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
